/* e100_control.sv */
// E100 instruction sequencing FSM and Wishbone master handshake
`timescale 1ns/1ps

module e100_control (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        run,
    e100_bus_if.ctl     bus,
    e100_ctrl_if.ctl    dp,
    output logic        halted
);

    e100_pkg::state_e state_q, state_d;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= e100_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        e100_pkg::latch_e tgt;
        logic             taken;

        tgt          = e100_pkg::LATCH_NONE;
        taken        = 1'b0;
        state_d      = state_q;
        bus.cyc      = 1'b0;
        bus.stb      = 1'b0;
        bus.we       = 1'b0;
        dp.addr_sel  = e100_pkg::ADDR_IAR;
        dp.exec      = 1'b0;
        dp.iar_inc   = 1'b0;
        dp.iar_jump  = 1'b0;
        dp.iar_clear = 1'b0;

        case (state_q)
            e100_pkg::IDLE: begin
                if (run) begin
                    dp.iar_clear = 1'b1;
                    state_d      = e100_pkg::FETCH_OP;
                end
            end
            e100_pkg::FETCH_OP: begin
                tgt = e100_pkg::LATCH_OPCODE;
                if (bus.ack) state_d = e100_pkg::FETCH_A1;
            end
            e100_pkg::FETCH_A1: begin
                tgt = e100_pkg::LATCH_ARG1;
                if (bus.ack) state_d = e100_pkg::FETCH_A2;
            end
            e100_pkg::FETCH_A2: begin
                tgt = e100_pkg::LATCH_ARG2;
                if (bus.ack) state_d = e100_pkg::FETCH_A3;
            end
            e100_pkg::FETCH_A3: begin
                tgt = e100_pkg::LATCH_ARG3;
                if (bus.ack) state_d = e100_pkg::READ_OP1;
            end
            e100_pkg::READ_OP1: begin
                tgt         = e100_pkg::LATCH_OP1;
                dp.addr_sel = e100_pkg::ADDR_ARG2;
                if (bus.ack) state_d = e100_pkg::READ_OP2;
            end
            e100_pkg::READ_OP2: begin
                tgt         = e100_pkg::LATCH_OP2;
                dp.addr_sel = e100_pkg::ADDR_ARG3;
                if (bus.ack) state_d = e100_pkg::EXEC;
            end
            e100_pkg::EXEC: begin
                case (dp.opcode)
                    e100_pkg::OP_BE, e100_pkg::OP_BNE, e100_pkg::OP_BLT: begin
                        if (dp.opcode == e100_pkg::OP_BE) taken = dp.eq;
                        else if (dp.opcode == e100_pkg::OP_BNE) taken = ~dp.eq;
                        else taken = dp.lt;
                        dp.iar_jump = taken;
                        dp.iar_inc  = ~taken;
                        state_d     = e100_pkg::FETCH_OP;    // no write back
                    end
                    e100_pkg::OP_ADD, e100_pkg::OP_SUB, e100_pkg::OP_MULT,
                    e100_pkg::OP_AND, e100_pkg::OP_OR, e100_pkg::OP_NOT,
                    e100_pkg::OP_SL, e100_pkg::OP_SR, e100_pkg::OP_CP: begin
                        dp.exec    = 1'b1;
                        dp.iar_inc = 1'b1;
                        state_d    = e100_pkg::WRITE;
                    end
                    default: state_d = e100_pkg::HALTED;  // halt and unknown opcodes
                endcase
            end
            e100_pkg::WRITE: begin
                bus.we      = 1'b1;
                dp.addr_sel = e100_pkg::ADDR_ARG1;
                if (bus.ack) state_d = e100_pkg::FETCH_OP;
            end
            default: ;                                   // HALTED until reset
        endcase

        // every fetch, read and write state is one bus access
        if (tgt != e100_pkg::LATCH_NONE || state_q == e100_pkg::WRITE) begin
            bus.cyc = 1'b1;
            bus.stb = 1'b1;
        end
    end

    // read data is only valid with ack
    assign dp.latch_sel = bus.ack ? tgt_sel(state_q) : e100_pkg::LATCH_NONE;

    function automatic e100_pkg::latch_e tgt_sel(input e100_pkg::state_e st);
        case (st)
            e100_pkg::FETCH_OP: return e100_pkg::LATCH_OPCODE;
            e100_pkg::FETCH_A1: return e100_pkg::LATCH_ARG1;
            e100_pkg::FETCH_A2: return e100_pkg::LATCH_ARG2;
            e100_pkg::FETCH_A3: return e100_pkg::LATCH_ARG3;
            e100_pkg::READ_OP1: return e100_pkg::LATCH_OP1;
            e100_pkg::READ_OP2: return e100_pkg::LATCH_OP2;
            default:            return e100_pkg::LATCH_NONE;
        endcase
    endfunction

    assign halted = (state_q == e100_pkg::HALTED);

endmodule

/* e100_datapath.sv */
// E100 datapath: IAR, instruction and operand registers, ALU and compare flags
`timescale 1ns/1ps

module e100_datapath (
    input  logic        clock,
    input  logic        rst_n,
    e100_bus_if.dp      bus,
    e100_ctrl_if.dp     ctl
);

    e100_pkg::word_t iar_q;
    logic [1:0]      fetch_off;     // word of the instruction being fetched
    e100_pkg::word_t opcode_q;
    e100_pkg::word_t arg1_q, arg2_q, arg3_q;
    e100_pkg::word_t op1_q, op2_q;
    e100_pkg::word_t result_q;
    e100_pkg::word_t alu;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            iar_q     <= '0;
            fetch_off <= '0;
        end else begin
            if (ctl.iar_clear) begin
                iar_q     <= '0;
                fetch_off <= '0;
            end else begin
                if (ctl.iar_jump) iar_q <= arg1_q;
                else if (ctl.iar_inc) iar_q <= iar_q + e100_pkg::word_t'(4);

                // opcode and three args, wraps back to 0 after arg3
                case (ctl.latch_sel)
                    e100_pkg::LATCH_OPCODE, e100_pkg::LATCH_ARG1,
                    e100_pkg::LATCH_ARG2, e100_pkg::LATCH_ARG3:
                        fetch_off <= fetch_off + 2'd1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        case (ctl.latch_sel)
            e100_pkg::LATCH_OPCODE: opcode_q <= bus.dat_r;
            e100_pkg::LATCH_ARG1:   arg1_q   <= bus.dat_r;
            e100_pkg::LATCH_ARG2:   arg2_q   <= bus.dat_r;
            e100_pkg::LATCH_ARG3:   arg3_q   <= bus.dat_r;
            e100_pkg::LATCH_OP1:    op1_q    <= bus.dat_r;
            e100_pkg::LATCH_OP2:    op2_q    <= bus.dat_r;
            default: ;
        endcase
        if (ctl.exec) result_q <= alu;
    end

    always_comb begin
        case (opcode_q)
            e100_pkg::OP_ADD:  alu = op1_q + op2_q;
            e100_pkg::OP_SUB:  alu = op1_q - op2_q;
            e100_pkg::OP_MULT: alu = op1_q * op2_q;    // low word only
            e100_pkg::OP_AND:  alu = op1_q & op2_q;
            e100_pkg::OP_OR:   alu = op1_q | op2_q;
            e100_pkg::OP_NOT:  alu = ~op1_q;
            e100_pkg::OP_SL:   alu = op1_q << op2_q[4:0];
            e100_pkg::OP_SR:   alu = op1_q >> op2_q[4:0];
            e100_pkg::OP_CP:   alu = op1_q;
            default:           alu = '0;
        endcase
    end

    always_comb begin
        case (ctl.addr_sel)
            e100_pkg::ADDR_ARG1: bus.adr = arg1_q;
            e100_pkg::ADDR_ARG2: bus.adr = arg2_q;
            e100_pkg::ADDR_ARG3: bus.adr = arg3_q;
            default:             bus.adr = iar_q + e100_pkg::word_t'(fetch_off);
        endcase
    end

    assign bus.dat_w  = result_q;
    assign ctl.opcode = opcode_q;
    assign ctl.eq     = (op1_q == op2_q);
    assign ctl.lt     = ($signed(op1_q) < $signed(op2_q));

endmodule

/* e100_defs.svh */
// word and RAM sizes, I/O port indices and widths, timer divider
`ifndef E100_DEFS_SVH
`define E100_DEFS_SVH

// machine word
`define WORD_W 32

// RAM holds 2**RAM_AW words
`define RAM_AW 10

// I/O port indices, low address bits when bit 31 is set
`define IO_SW        8'd0
`define IO_LED_RED   8'd1
`define IO_LED_GREEN 8'd2
`define IO_TIMER     8'd5

// port widths
`define SW_W        18
`define LED_RED_W   18
`define LED_GREEN_W 8

// clocks per timer increment
`define TICK_DIV 8

`endif

/* e100_if.sv */
// Wishbone classic bus interface and control-to-datapath interface
`timescale 1ns/1ps

interface e100_bus_if;

    logic                cyc;
    logic                stb;
    logic                we;
    e100_pkg::word_t     adr;
    e100_pkg::word_t     dat_w;
    e100_pkg::word_t     dat_r;
    logic                ack;

    // master is split between control (handshake) and datapath (address, data)
    modport ctl (output cyc, stb, we, input ack);
    modport dp  (output adr, dat_w, input dat_r);
    modport slv (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

interface e100_ctrl_if;

    e100_pkg::latch_e    latch_sel;
    e100_pkg::addr_e     addr_sel;
    logic                exec;          // result register takes the ALU output
    logic                iar_inc;       // next instruction, IAR + 4
    logic                iar_jump;      // branch taken, IAR from arg1
    logic                iar_clear;
    e100_pkg::word_t     opcode;
    logic                eq;
    logic                lt;            // signed

    modport ctl (
        output latch_sel, addr_sel, exec, iar_inc, iar_jump, iar_clear,
        input  opcode, eq, lt
    );
    modport dp (
        input  latch_sel, addr_sel, exec, iar_inc, iar_jump, iar_clear,
        output opcode, eq, lt
    );

endinterface

/* e100_io_ports.sv */
// switch input, red and green LED registers and timer port
`timescale 1ns/1ps
`include "e100_defs.svh"

module e100_io_ports (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [7:0]                port_idx,
    input  logic                      port_we,
    input  e100_pkg::word_t           wdata,
    output e100_pkg::word_t           rdata,
    input  logic [`SW_W-1:0]          sw,
    output logic [`LED_RED_W-1:0]     led_red,
    output logic [`LED_GREEN_W-1:0]   led_green
);

    e100_pkg::word_t timer_count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            led_red   <= '0;
            led_green <= '0;
        end else if (port_we) begin
            if (port_idx == `IO_LED_RED) led_red <= wdata[`LED_RED_W-1:0];
            if (port_idx == `IO_LED_GREEN) led_green <= wdata[`LED_GREEN_W-1:0];
        end
    end

    always_comb begin
        case (port_idx)
            `IO_SW:        rdata = e100_pkg::word_t'(sw);
            `IO_LED_RED:   rdata = e100_pkg::word_t'(led_red);
            `IO_LED_GREEN: rdata = e100_pkg::word_t'(led_green);
            `IO_TIMER:     rdata = timer_count;
            default:       rdata = '0;        // unmapped port
        endcase
    end

    e100_timer u_timer (
        .clock (clock),
        .rst_n (rst_n),
        .count (timer_count)
    );

endmodule

/* e100_mem.sv */
// Wishbone slave with the word RAM, program load port and I/O dispatch
`timescale 1ns/1ps
`include "e100_defs.svh"

module e100_mem (
    input  logic                      clock,
    input  logic                      rst_n,
    e100_bus_if.slv                   bus,
    input  logic                      load_we,
    input  logic [`RAM_AW-1:0]        load_addr,
    input  e100_pkg::word_t           load_data,
    input  logic [`SW_W-1:0]          sw,
    output logic [`LED_RED_W-1:0]     led_red,
    output logic [`LED_GREEN_W-1:0]   led_green
);

    e100_pkg::word_t ram [0:(1 << `RAM_AW)-1];
    e100_pkg::word_t io_rdata;
    logic            req;
    logic            io_sel;

    assign req    = bus.cyc & bus.stb & ~bus.ack;  // one ack per strobe
    assign io_sel = bus.adr[31];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    always_ff @(posedge clock) begin
        if (load_we) begin
            ram[load_addr] <= load_data;
        end else if (req && bus.we && !io_sel) begin
            ram[bus.adr[`RAM_AW-1:0]] <= bus.dat_w;
        end
    end

    // held through the ack clock
    always_ff @(posedge clock) begin
        if (req) bus.dat_r <= io_sel ? io_rdata : ram[bus.adr[`RAM_AW-1:0]];
    end

    e100_io_ports u_io_ports (
        .clock     (clock),
        .rst_n     (rst_n),
        .port_idx  (bus.adr[7:0]),
        .port_we   (req & bus.we & io_sel),
        .wdata     (bus.dat_w),
        .rdata     (io_rdata),
        .sw        (sw),
        .led_red   (led_red),
        .led_green (led_green)
    );

endmodule

/* e100_pkg.sv */
// word type, opcodes, control states and datapath steering selects
`include "e100_defs.svh"

package e100_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    // original E100 opcode numbers, dropped ones left out
    typedef enum logic [31:0] {
        OP_HALT = 32'd0,
        OP_ADD  = 32'd1,
        OP_SUB  = 32'd2,
        OP_MULT = 32'd3,
        OP_CP   = 32'd5,
        OP_AND  = 32'd6,
        OP_OR   = 32'd7,
        OP_NOT  = 32'd8,
        OP_SL   = 32'd9,
        OP_SR   = 32'd10,
        OP_BE   = 32'd13,
        OP_BNE  = 32'd14,
        OP_BLT  = 32'd15
    } opcode_e;

    typedef enum logic [3:0] {
        IDLE,
        FETCH_OP,
        FETCH_A1,
        FETCH_A2,
        FETCH_A3,
        READ_OP1,
        READ_OP2,
        EXEC,
        WRITE,
        HALTED
    } state_e;

    // register that takes the bus read data
    typedef enum logic [2:0] {
        LATCH_NONE,
        LATCH_OPCODE,
        LATCH_ARG1,
        LATCH_ARG2,
        LATCH_ARG3,
        LATCH_OP1,
        LATCH_OP2
    } latch_e;

    // register that drives the bus address
    typedef enum logic [1:0] {
        ADDR_IAR,
        ADDR_ARG1,
        ADDR_ARG2,
        ADDR_ARG3
    } addr_e;

endpackage

/* e100_timer.sv */
// free-running tick counter behind a TICK_DIV prescaler
`timescale 1ns/1ps
`include "e100_defs.svh"

module e100_timer (
    input  logic            clock,
    input  logic            rst_n,
    output e100_pkg::word_t count
);

    localparam int PRE_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;

    logic [PRE_W-1:0] pre;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pre   <= '0;
            count <= '0;
        end else if (pre == PRE_W'(`TICK_DIV - 1)) begin
            pre   <= '0;
            count <= count + e100_pkg::word_t'(1);    // wraps
        end else begin
            pre <= pre + PRE_W'(1);
        end
    end

endmodule

/* e100_top.sv */
// E100 core top level: control, datapath and memory on one Wishbone bus
`timescale 1ns/1ps
`include "e100_defs.svh"

module e100_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      load_we,
    input  logic [`RAM_AW-1:0]        load_addr,
    input  logic [`WORD_W-1:0]        load_data,
    input  logic [`SW_W-1:0]          sw,
    output logic [`LED_RED_W-1:0]     led_red,
    output logic [`LED_GREEN_W-1:0]   led_green,
    output logic                      halted
);

    e100_bus_if  bus_if ();
    e100_ctrl_if ctrl_if ();

    e100_control u_control (
        .clock  (clock),
        .rst_n  (rst_n),
        .run    (run),
        .bus    (bus_if.ctl),
        .dp     (ctrl_if.ctl),
        .halted (halted)
    );

    e100_datapath u_datapath (
        .clock (clock),
        .rst_n (rst_n),
        .bus   (bus_if.dp),
        .ctl   (ctrl_if.dp)
    );

    e100_mem u_mem (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus       (bus_if.slv),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .sw        (sw),
        .led_red   (led_red),
        .led_green (led_green)
    );

endmodule

/* run.sh */
#!/bin/sh
# builds the E100 testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_e100 -o tb_e100_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_e100_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

/* tb.f */
+incdir+.
e100_pkg.sv
e100_if.sv
e100_timer.sv
e100_io_ports.sv
e100_mem.sv
e100_datapath.sv
e100_control.sv
e100_top.sv
tb_e100.sv

/* tb_e100.sv */
// testbench for the E100 core: loads programs, runs them and checks the LED ports
`timescale 1ns/1ps
`include "e100_defs.svh"

module tb_e100;

    localparam int RUN_LIMIT = 20000;   // clocks allowed per program
    localparam int HOLD_CLKS = 8;       // clocks after halt that the LEDs must hold

    logic                    clock;
    logic                    rst_n;
    logic                    run;
    logic                    load_we;
    logic [`RAM_AW-1:0]      load_addr;
    logic [`WORD_W-1:0]      load_data;
    logic [`SW_W-1:0]        sw;
    logic [`LED_RED_W-1:0]   led_red;
    logic [`LED_GREEN_W-1:0] led_green;
    logic                    halted;

    integer      seed;
    logic [31:0] sw_val;                // last switch value driven
    string       tok [0:15];
    int          ntok;

    e100_top DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .run       (run),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .sw        (sw),
        .led_red   (led_red),
        .led_green (led_green),
        .halted    (halted)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // whitespace separated tokens of one pattern line
    task split_line(input string line);
        string cur;
        byte   c;
        int    i;
        cur  = "";
        ntok = 0;
        for (i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line.getc(i) : 8'h20;
            if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (cur.len() > 0 && ntok < 16) begin
                    tok[ntok] = cur;
                    ntok++;
                end
                cur = "";
            end else begin
                cur = $sformatf("%s%c", cur, c);
            end
        end
    endtask

    function automatic logic [31:0] value_of(input string t);
        if (t == "sw") return sw_val;   // stands for the driven switches
        return t.atohex();
    endfunction

    task load_words();
        logic [31:0] addr;
        int          i;
        addr = tok[1].atohex();
        for (i = 2; i < ntok; i++) begin
            @(posedge clock);
            load_we   <= 1'b1;
            load_addr <= addr[`RAM_AW-1:0];
            load_data <= tok[i].atohex();
            addr = addr + 32'd1;
        end
        @(posedge clock);
        load_we <= 1'b0;
    endtask

    task set_switches();
        if (tok[1] == "random") sw_val = $random(seed);
        else sw_val = tok[1].atohex();
        sw_val = sw_val & ((32'd1 << `SW_W) - 32'd1);
        @(posedge clock);
        sw <= sw_val[`SW_W-1:0];
    endtask

    task run_program();
        int n;
        n = 0;
        @(posedge clock);
        run <= 1'b1;
        @(negedge clock);
        while (!halted && n < RUN_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!halted) abort_run("timeout: the core did not halt");
        @(posedge clock);
        run <= 1'b0;
        repeat (HOLD_CLKS) @(negedge clock);
        check_value("halted", 32'd1, 32'(halted));   // stays set until reset
    endtask

    task expect_leds();
        logic [31:0] red_exp;
        logic [31:0] green_exp;
        red_exp   = value_of(tok[1]) & ((32'd1 << `LED_RED_W) - 32'd1);
        green_exp = value_of(tok[2]) & ((32'd1 << `LED_GREEN_W) - 32'd1);
        @(negedge clock);
        check_value("led_red", red_exp, 32'(led_red));
        check_value("led_green", green_exp, 32'(led_green));
    endtask

    task apply_reset();
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_value("halted", 32'd0, 32'(halted));
    endtask

    initial begin
        int    fd;
        string line;
        int    lineno;
        seed      = 32'he694;
        sw_val    = '0;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        sw        = '0;
        lineno    = 0;

        fd = $fopen("tb_e100_patterns.txt", "r");
        if (fd == 0) abort_run("cannot open tb_e100_patterns.txt");

        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            lineno++;
            split_line(line);
            if (ntok == 0 || tok[0].getc(0) == "#") continue;   // blank or comment
            if (tok[0] == "L" && ntok >= 3) begin
                load_words();
            end else if (tok[0] == "S" && ntok == 2) begin
                set_switches();
            end else if (tok[0] == "R") begin
                run_program();
            end else if (tok[0] == "E" && ntok == 3) begin
                expect_leds();
            end else if (tok[0] == "X") begin
                apply_reset();
            end else begin
                abort_run($sformatf("bad pattern line %0d: %s", lineno, line));
            end
        end
        $fclose(fd);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb_e100_patterns.txt */
# L addr w0 w1 ... loads words from addr up | S value or random sets switches | R runs to halt
# E red green expects LEDs, sw means the switch value | X resets | values in hex
# add, mult, sub to red and and to green
L 0 1 43 40 41
L 4 3 44 43 40
L 8 2 80000001 44 41
L c 6 80000002 43 42
L 10 0 0 0 0
L 40 1234 567 ff0
R
E 1ac15 90
X
E 0 0
# sl, or, sr to red and not to green
L 0 9 43 40 41
L 4 7 44 43 42
L 8 a 80000001 44 41
L c 8 80000002 40 0
L 10 0 0 0 0
L 40 f00f 4 a000
R
E fa0f f0
X
E 0 0
# branches with a negative operand in blt
L 0 f c 80 81
L 4 5 80000002 83 0
L 8 0 0 0 0
L c d 18 80 81
L 10 5 80000001 82 0
L 14 e 20 81 80
L 18 0 0 0 0
L 20 d 2c 81 81
L 24 5 80000002 83 0
L 28 0 0 0 0
L 2c 5 80000002 84 0
L 30 f 38 81 80
L 34 5 80000002 85 0
L 38 0 0 0 0
L 80 fffffffb 3 11 22 33 44
R
E 11 44
X
E 0 0
# switches to red and their low byte to green
L 0 5 80000001 80000000 0
L 4 6 80000002 80000000 90
L 8 0 0 0 0
L 90 ff
S 2a5c3
R
E sw sw
X
E 0 0
S random
R
E sw sw
X
E 0 0
# timer read, delay loop, second read, blt picks 1 if it advanced
L 0 5 a0 80000005 0
L 4 1 a2 a2 a1
L 8 e 4 a2 a3
L c 5 a4 80000005 0
L 10 f 1c a0 a4
L 14 5 80000002 a6 0
L 18 0 0 0 0
L 1c 5 80000002 a5 0
L 20 0 0 0 0
L a0 0 1 0 3 0 1 2
R
E 0 1
X
E 0 0
